/* sources.f */
source/crtcPkg.sv
source/ulaPkg.sv
source/crtcVideoIf.sv
source/clockEnables.sv
source/crtc6845.sv
source/videoUla.sv
source/displayControl.sv
verif/displayControl_chk.sv
verif/displayControl_tb.sv

/* Makefile */
SOURCES := $(shell cat sources.f)

obj_dir/VdisplayControl_tb: sources.f $(SOURCES)
	verilator --binary --timing --assert -f sources.f \
		--top-module displayControl_tb -o VdisplayControl_tb

run: obj_dir/VdisplayControl_tb
	./obj_dir/VdisplayControl_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* verif/display_golden.txt */
// Columns: op (8 bits), sel (8 bits), value (16 bits), one hex word per line
// 01 CRTC write, 02 ULA write, 03/04 sync periods, 05 address walk, 06 read back, 07 pixels, 08 txtMode
0F0C1408
01000007
01010004
01020005
01030021
01040001
01050000
01060001
01070001
01090009
010A0000
010B0009
010C0003
010D0000
010E0003
010F0001
03000080
04000A00
05000000
060E0003
060F0001
020100FA
02010003
07AA0054
02000001
07AA0024
07AA0800
02000080
07AA0023
02000002
08000001
07AA0000
00000000

/* verif/displayControl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module displayControl_tb;

	logic        CLK, nRESET, procEn, nCsCrtc, nCsUla, rnw, a0;
	logic [7:0]  cpuData, cpuReadData;
	logic [7:0]  vData = 8'h00;
	logic        hsync, vsync, txtMode;
	logic [2:0]  rgb;
	logic [13:0] framestoreAdr;
	logic [4:0]  rowAddress;
	logic [31:0] golden [0:63];
	logic [7:0]  crtcRegs [16]; // Shadow of the values written to the CRTC
	logic        holdVideo;
	logic [7:0]  fixedByte;
	int unsigned lcgState = 69;
	int          limitCycles = 0;
	int          idx, cycles;

	displayControl i_dut (
		.CLK(CLK), .nRESET(nRESET), .procEn(procEn), .nCsCrtc(nCsCrtc), .nCsUla(nCsUla),
		.rnw(rnw), .a0(a0), .cpuData(cpuData), .vData(vData), .cpuReadData(cpuReadData),
		.hsync(hsync), .vsync(vsync), .txtMode(txtMode), .rgb(rgb),
		.framestoreAdr(framestoreAdr), .rowAddress(rowAddress)
	);

	function automatic logic [7:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[23:16];
	endfunction

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) vData <= holdVideo ? fixedByte : nextRandom();

	initial begin
		wait (limitCycles != 0);
		repeat (limitCycles) @(posedge CLK);
		$display("Timeout: the display did not reach the end of the golden file in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "Watchdog expired");
	end

	task automatic checkValue(input string what, input int got, input int expected);
		if (got !== expected) begin
			$display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "Check failed");
		end
	endtask

	task automatic writeCrtc(input logic [4:0] regNum, input logic [7:0] data);
		@(posedge CLK);
		procEn  <= 1'b1;
		nCsCrtc <= 1'b0;
		rnw     <= 1'b0;
		a0      <= 1'b0;
		cpuData <= {3'b000, regNum};
		@(posedge CLK);
		a0      <= 1'b1;
		cpuData <= data;
		@(posedge CLK);
		procEn  <= 1'b0;
		nCsCrtc <= 1'b1;
		rnw     <= 1'b1;
		crtcRegs[regNum[3:0]] = data;
	endtask

	task automatic writeUla(input logic sel, input logic [7:0] data);
		ulaPkg::ulaWrite_u word;
		word = data;
		if (!sel && word.control.pixelRate != ulaPkg::pixRate2) begin
			$display("Golden file selects a pixel rate that the pixel checks do not support");
			$display("SOME TESTS FAILED");
			$fatal(1, "Bad golden file");
		end
		@(posedge CLK);
		procEn  <= 1'b1;
		nCsUla  <= 1'b0;
		a0      <= sel;
		cpuData <= word;
		@(posedge CLK);
		procEn  <= 1'b0;
		nCsUla  <= 1'b1;
	endtask

	// Read back is combinational, so it is sampled in the same cycle
	task automatic readCrtc(input logic [4:0] regNum, input logic [7:0] expected);
		@(posedge CLK);
		procEn  <= 1'b1;
		nCsCrtc <= 1'b0;
		rnw     <= 1'b0;
		a0      <= 1'b0;
		cpuData <= {3'b000, regNum};
		@(posedge CLK);
		procEn  <= 1'b0;
		rnw     <= 1'b1;
		a0      <= 1'b1;
		@(negedge CLK);
		checkValue("cpuReadData", int'(cpuReadData), int'(expected));
		@(posedge CLK);
		nCsCrtc <= 1'b1;
	endtask

	task automatic waitRise(input logic useVsync, output int count);
		logic last, now;
		last  = 1'b1;
		now   = 1'b1;
		count = 0;
		while (!(now && !last)) begin
			@(negedge CLK);
			count++;
			last = now;
			now  = useVsync ? vsync : hsync;
		end
	endtask

	// Follows every line of one frame, starting at the vsync row
	task automatic walkAddresses();
		logic [13:0] start, expAdr;
		logic [4:0]  lastRow;
		int          rowIdx, scan, line, skip;
		start = {crtcRegs[12][5:0], crtcRegs[13]};
		waitRise(1'b1, skip);
		rowIdx = int'(crtcRegs[7]);
		scan   = 0;
		for (line = 0; line < (crtcRegs[4] + 1) * (crtcRegs[9] + 1); line++) begin
			expAdr = start + 14'(rowIdx * int'(crtcRegs[1]));
			checkValue("rowAddress", int'(rowAddress), scan);
			checkValue("framestoreAdr", int'(framestoreAdr), int'(expAdr));
			lastRow = rowAddress;
			while (rowAddress == lastRow) @(negedge CLK);
			scan++;
			if (scan > int'(crtcRegs[9])) begin
				scan = 0;
				rowIdx = (rowIdx == int'(crtcRegs[4])) ? 0 : rowIdx + 1;
			end
		end
	endtask

	task automatic checkPixels(input logic [7:0] byteVal, input logic [15:0] expected);
		logic [13:0] target, lastAdr;
		target = {crtcRegs[12][5:0], crtcRegs[13]} + 14'd2; // Third character of row 0
		@(posedge CLK);
		holdVideo <= 1'b1;
		fixedByte <= byteVal;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		lastAdr = framestoreAdr;
		@(negedge CLK);
		while (!(framestoreAdr == target && lastAdr != target
			&& rowAddress == expected[12:8])) begin
			lastAdr = framestoreAdr;
			@(negedge CLK);
		end
		checkValue("rgb of first pixel", int'(rgb), int'(expected[7:4]));
		repeat (8) @(negedge CLK); // One 2 MHz shift later
		checkValue("rgb of second pixel", int'(rgb), int'(expected[3:0]));
		@(posedge CLK);
		holdVideo <= 1'b0;
	endtask

	initial begin
		nRESET    = 1'b0;
		procEn    = 1'b0;
		nCsCrtc   = 1'b1;
		nCsUla    = 1'b1;
		rnw       = 1'b1;
		a0        = 1'b0;
		cpuData   = 8'h00;
		holdVideo = 1'b0;
		fixedByte = 8'h00;
		$readmemh("verif/display_golden.txt", golden);
		limitCycles = int'(golden[0][23:16]) * int'(golden[0][15:8]) * int'(golden[0][7:0]) * 32;
		repeat (2) @(posedge CLK);
		nRESET <= 1'b1;
		idx = 1;
		while (golden[idx][31:24] != 8'h00) begin
			case (golden[idx][31:24])
				8'h01: writeCrtc(golden[idx][20:16], golden[idx][7:0]);
				8'h02: writeUla(golden[idx][16], golden[idx][7:0]);
				8'h03, 8'h04: begin
					waitRise(golden[idx][24] == 1'b0, cycles); // Op 04 selects vsync
					waitRise(golden[idx][24] == 1'b0, cycles);
					checkValue("sync period", cycles, int'(golden[idx][15:0]));
				end
				8'h05: walkAddresses();
				8'h06: readCrtc(golden[idx][20:16], golden[idx][7:0]);
				8'h07: checkPixels(golden[idx][23:16], golden[idx][15:0]);
				8'h08: begin
					@(negedge CLK);
					checkValue("txtMode", int'(txtMode), int'(golden[idx][15:0]));
				end
				default: begin
					$display("Golden file holds an unknown operation at line %0d", idx);
					$display("SOME TESTS FAILED");
					$fatal(1, "Bad golden file");
				end
			endcase
			idx++;
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/displayControl_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module displayControl_chk (
	input logic                         CLK,
	input logic                         nRESET,
	input logic                         hsync,
	input logic                         vsync,
	input logic                         disEn,
	input logic [3:0]                   hsCount,
	input logic [3:0]                   hsWidth,
	input logic [crtcPkg::adrWidth-1:0] framestoreAdr
);

	// A zero width means sixteen characters, which the counter cannot exceed
	hsyncWidth: assert property (@(posedge CLK) disable iff (!nRESET)
		hsync && hsWidth != 4'd0 |-> hsCount <= hsWidth)
		else $error("hsync is longer than its programmed width");

	blankInVsync: assert property (@(posedge CLK) disable iff (!nRESET)
		vsync |-> !disEn)
		else $error("display enable is high during vsync");

	syncsAfterReset: assert property (@(posedge CLK) !nRESET |=> !hsync && !vsync)
		else $error("sync output is high after reset");

	adrAfterReset: assert property (@(posedge CLK) !nRESET |=> framestoreAdr == '0)
		else $error("framestore address is not cleared by reset");

endmodule

bind crtc6845 displayControl_chk uChk (
	.CLK           (CLK),
	.nRESET        (nRESET),
	.hsync         (hsync),
	.vsync         (vsync),
	.disEn         (vid.disEn),
	.hsCount       (hsCount),
	.hsWidth       (regFile[crtcPkg::regSyncWidth][3:0]),
	.framestoreAdr (framestoreAdr)
);

`default_nettype wire

/* source/displayControl.sv */
`timescale 1ns/1ps
`default_nettype none

module displayControl (
	input  logic                          CLK,
	input  logic                          nRESET,
	input  logic                          procEn,
	input  logic                          nCsCrtc,
	input  logic                          nCsUla,
	input  logic                          rnw,
	input  logic                          a0,
	input  logic [7:0]                    cpuData,
	input  logic [7:0]                    vData,
	output logic [7:0]                    cpuReadData,
	output logic                          hsync,
	output logic                          vsync,
	output logic                          txtMode,
	output logic [2:0]                    rgb,
	output logic [crtcPkg::adrWidth-1:0]  framestoreAdr,
	output logic [crtcPkg::rowWidth-1:0]  rowAddress
);

	logic en8, en4, en2, en1, en2v;

	crtcVideoIf vidBus ();

	clockEnables uEnables (
		.CLK    (CLK),
		.nRESET (nRESET),
		.en8    (en8),
		.en4    (en4),
		.en2    (en2),
		.en1    (en1),
		.en2v   (en2v)
	);

	crtc6845 uCrtc (
		.CLK           (CLK),
		.nRESET        (nRESET),
		.procEn        (procEn),
		.nCsCrtc       (nCsCrtc),
		.rnw           (rnw),
		.a0            (a0),
		.cpuData       (cpuData),
		.cpuReadData   (cpuReadData),
		.hsync         (hsync),
		.vsync         (vsync),
		.framestoreAdr (framestoreAdr),
		.rowAddress    (rowAddress),
		.vid           (vidBus.crtc)
	);

	videoUla uUla (
		.CLK     (CLK),
		.nRESET  (nRESET),
		.en8     (en8),
		.en4     (en4),
		.en2     (en2),
		.en1     (en1),
		.en2v    (en2v),
		.procEn  (procEn),
		.nCsUla  (nCsUla),
		.a0      (a0),
		.cpuData (cpuData),
		.vData   (vData),
		.rgb     (rgb),
		.txtMode (txtMode),
		.vid     (vidBus.ula)
	);

endmodule

`default_nettype wire

/* source/videoUla.sv */
`timescale 1ns/1ps
`default_nettype none

module videoUla (
	input  logic       CLK,
	input  logic       nRESET,
	input  logic       en8,
	input  logic       en4,
	input  logic       en2,
	input  logic       en1,
	input  logic       en2v,
	input  logic       procEn,
	input  logic       nCsUla,
	input  logic       a0,
	input  logic [7:0] cpuData,
	input  logic [7:0] vData,
	output logic [2:0] rgb,
	output logic       txtMode,
	crtcVideoIf.ula    vid
);

	ulaPkg::ulaWrite_u wrWord;
	ulaPkg::ulaWrite_u ctl;
	logic [3:0]        palette [16];
	logic [7:0]        shifter;
	logic              pixEn;
	logic [2:0]        cursorHist;
	logic [3:0]        cursorSeg;
	logic              cursorDraw;
	logic [3:0]        logical;
	logic [3:0]        physical;
	logic [2:0]        colour;
	logic [2:0]        pixel;

	assign wrWord = cpuData;

	always_ff @(posedge CLK) begin
		if (!nRESET)
			ctl <= '0;
		else if (procEn && !nCsUla && !a0)
			ctl <= wrWord;
	end

	always_ff @(posedge CLK) begin
		if (procEn && !nCsUla && a0)
			palette[wrWord.palette.logical] <= wrWord.palette.physical;
	end

	assign txtMode    = ctl.control.teletext;
	assign vid.charEn = ctl.control.fastChar ? en2v : en1;

	always_comb begin
		case (ctl.control.pixelRate)
			ulaPkg::pixRate2:  pixEn = en2;
			ulaPkg::pixRate4:  pixEn = en4;
			ulaPkg::pixRate8:  pixEn = en8;
			ulaPkg::pixRate16: pixEn = 1'b1;
			default:           pixEn = en2;
		endcase
	end

	// New byte every character, ones shifted in behind the pixels
	always_ff @(posedge CLK) begin
		if (vid.charEn)
			shifter <= vData;
		else if (pixEn)
			shifter <= {shifter[6:0], 1'b1};
	end

	// History of the cursor flag, one character per step
	always_ff @(posedge CLK) begin
		if (!nRESET)
			cursorHist <= '0;
		else if (vid.charEn)
			cursorHist <= {cursorHist[1:0], vid.cursor};
	end

	assign cursorSeg  = {cursorHist, vid.cursor}; // Segment 0 is the cursor character itself
	assign cursorDraw = (ctl.control.cursorSeg0 && cursorSeg[0])
		|| (ctl.control.cursorSeg1 && cursorSeg[1])
		|| (ctl.control.cursorSeg23 && (cursorSeg[2] || cursorSeg[3]));

	assign logical  = {shifter[7], shifter[5], shifter[3], shifter[1]};
	assign physical = palette[logical];

	// Colours come out inverted unless flashing is on and the entry asks for it
	assign colour = (physical[3] && ctl.control.flash) ? physical[2:0] : ~physical[2:0];

	always_comb begin
		if (ctl.control.teletext)
			pixel = 3'b000; // No teletext generator in this design
		else if (vid.disEn && !vid.rowHigh)
			pixel = colour;
		else
			pixel = 3'b000;
	end

	assign rgb = cursorDraw ? ~pixel : pixel;

endmodule

`default_nettype wire

/* source/crtc6845.sv */
`timescale 1ns/1ps
`default_nettype none

module crtc6845 (
	input  logic                          CLK,
	input  logic                          nRESET,
	input  logic                          procEn,
	input  logic                          nCsCrtc,
	input  logic                          rnw,
	input  logic                          a0,
	input  logic [7:0]                    cpuData,
	output logic [7:0]                    cpuReadData,
	output logic                          hsync,
	output logic                          vsync,
	output logic [crtcPkg::adrWidth-1:0]  framestoreAdr,
	output logic [crtcPkg::rowWidth-1:0]  rowAddress,
	crtcVideoIf.crtc                      vid
);

	logic [4:0]                           adrReg;
	logic [15:0][7:0]                     regFile;
	logic [crtcPkg::hCountWidth-1:0]      hCount;
	logic [crtcPkg::rowWidth-1:0]         scanLine, scanNext;
	logic [crtcPkg::rowCountWidth-1:0]    rowCount, rowNext;
	logic                                 inAdjust, adjNext;
	logic [3:0]                           hsCount, vsCount;
	logic [crtcPkg::adrWidth-1:0]         ma, rowAdr, rowStep, startAdr, cursorAdr;
	logic                                 lineEnd, rowStart, frameStart;
	logic                                 hDisp, vDisp, cursorHit;

	// Processor writes, a0 picks the address register or the selected data register
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			adrReg  <= '0;
			regFile <= crtcPkg::regResetValues;
		end else if (procEn && !nCsCrtc && !rnw) begin
			if (!a0)
				adrReg <= cpuData[4:0];
			else if (!adrReg[4])
				regFile[adrReg[3:0]] <= cpuData;
		end
	end

	// Only the cursor address can be read back
	always_comb begin
		cpuReadData = 8'h00;
		if (!nCsCrtc && rnw && a0) begin
			if (adrReg == crtcPkg::regCursorHi)
				cpuReadData = regFile[crtcPkg::regCursorHi];
			else if (adrReg == crtcPkg::regCursorLo)
				cpuReadData = regFile[crtcPkg::regCursorLo];
		end
	end

	assign startAdr  = {regFile[crtcPkg::regStartAddrHi][5:0], regFile[crtcPkg::regStartAddrLo]};
	assign cursorAdr = {regFile[crtcPkg::regCursorHi][5:0], regFile[crtcPkg::regCursorLo]};
	assign rowStep   = {{(crtcPkg::adrWidth-8){1'b0}}, regFile[crtcPkg::regHorizDisplayed]};
	assign lineEnd   = hCount == regFile[crtcPkg::regHorizTotal];

	// Vertical state after the current scan line ends
	always_comb begin
		scanNext = scanLine + 1'b1;
		rowNext  = rowCount;
		adjNext  = inAdjust;
		if (inAdjust) begin
			if (scanLine == regFile[crtcPkg::regVertAdjust][4:0] - 5'd1) begin
				scanNext = '0;
				rowNext  = '0;
				adjNext  = 1'b0;
			end
		end else if (scanLine == regFile[crtcPkg::regMaxScanLine][4:0]) begin
			scanNext = '0;
			if (rowCount != regFile[crtcPkg::regVertTotal][6:0])
				rowNext = rowCount + 1'b1;
			else if (regFile[crtcPkg::regVertAdjust][4:0] == '0)
				rowNext = '0; // No adjust lines, straight into the next frame
			else begin
				rowNext = rowCount + 1'b1;
				adjNext = 1'b1;
			end
		end
	end

	assign rowStart   = (scanNext == '0) && !adjNext;
	assign frameStart = rowStart && (rowNext == '0);

	assign hDisp     = hCount < regFile[crtcPkg::regHorizDisplayed];
	assign vDisp     = !inAdjust && (rowCount < regFile[crtcPkg::regVertDisplayed][6:0]);
	assign cursorHit = (ma == cursorAdr) && hDisp && vDisp
		&& (scanLine >= regFile[crtcPkg::regCursorStart][4:0])
		&& (scanLine <= regFile[crtcPkg::regCursorEnd][4:0]);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			hCount     <= '0;
			scanLine   <= '0;
			rowCount   <= '0;
			inAdjust   <= 1'b0;
			hsync      <= 1'b0;
			vsync      <= 1'b0;
			hsCount    <= '0;
			vsCount    <= '0;
			ma         <= '0;
			rowAdr     <= '0;
			vid.disEn  <= 1'b0;
			vid.cursor <= 1'b0;
		end else if (vid.charEn) begin
			hCount <= lineEnd ? '0 : hCount + 1'b1;

			// A width of zero wraps the counter and gives sixteen
			if (hCount == regFile[crtcPkg::regHorizSyncPos]) begin
				hsync   <= 1'b1;
				hsCount <= 4'd1;
			end else if (hsync) begin
				if (hsCount == regFile[crtcPkg::regSyncWidth][3:0])
					hsync <= 1'b0;
				hsCount <= hsCount + 1'b1;
			end

			if (lineEnd) begin
				scanLine <= scanNext;
				rowCount <= rowNext;
				inAdjust <= adjNext;
				if (rowStart && (rowNext == regFile[crtcPkg::regVertSyncPos][6:0])) begin
					vsync   <= 1'b1;
					vsCount <= 4'd1;
				end else if (vsync) begin
					if (vsCount == regFile[crtcPkg::regSyncWidth][7:4])
						vsync <= 1'b0;
					vsCount <= vsCount + 1'b1;
				end

				if (frameStart) begin
					ma     <= startAdr;
					rowAdr <= startAdr;
				end else if (rowStart) begin
					ma     <= rowAdr + rowStep;
					rowAdr <= rowAdr + rowStep;
				end else
					ma <= rowAdr; // Same character row again
			end else
				ma <= ma + 1'b1;

			vid.disEn  <= hDisp && vDisp; // Lines up with the byte the ULA loads next
			vid.cursor <= cursorHit;
		end
	end

	assign framestoreAdr = ma;
	assign rowAddress    = scanLine;
	assign vid.rowLow    = scanLine[0];
	assign vid.rowHigh   = scanLine[3];

endmodule

`default_nettype wire

/* source/clockEnables.sv */
`timescale 1ns/1ps
`default_nettype none

module clockEnables (
	input  logic CLK,
	input  logic nRESET,
	output logic en8,
	output logic en4,
	output logic en2,
	output logic en1,
	output logic en2v
);

	logic [3:0] phase;
	logic [3:0] en2Delay;

	// Sixteen cycle phase counter, CLK itself is the 16 MHz rate
	always_ff @(posedge CLK) begin
		if (!nRESET)
			phase <= '0;
		else
			phase <= phase + 4'd1;
	end

	assign en8 = phase[0];
	assign en4 = &phase[1:0];
	assign en2 = &phase[2:0];
	assign en1 = &phase; // One cycle in sixteen

	// Second 2 MHz phase, half a 2 MHz period after en2
	always_ff @(posedge CLK) begin
		if (!nRESET)
			en2Delay <= '0;
		else
			en2Delay <= {en2Delay[2:0], en2};
	end

	assign en2v = en2Delay[3];

endmodule

`default_nettype wire

/* source/crtcVideoIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface crtcVideoIf;

	logic charEn;  // Character clock enable chosen by the ULA
	logic disEn;   // Registered display enable
	logic cursor;  // Registered cursor hit, aligned with disEn
	logic rowLow;  // Lowest row address bit
	logic rowHigh; // Row address bit 3, set on rows 8 and above

	modport crtc (
		input  charEn,
		output disEn, cursor, rowLow, rowHigh
	);

	modport ula (
		input  disEn, cursor, rowLow, rowHigh,
		output charEn
	);

endinterface

`default_nettype wire

/* source/ulaPkg.sv */
`default_nettype none

package ulaPkg;

	// A0 low writes the control view, A0 high writes one palette entry
	typedef union packed {
		struct packed {
			logic       cursorSeg0;
			logic       cursorSeg1;
			logic       cursorSeg23; // Enables both of the last two segments
			logic       fastChar;    // Character clock at 2 MHz when set
			logic [1:0] pixelRate;
			logic       teletext;
			logic       flash;
		} control;
		struct packed {
			logic [3:0] logical;
			logic [3:0] physical;
		} palette;
	} ulaWrite_u;

	localparam logic [1:0] pixRate2  = 2'b00;
	localparam logic [1:0] pixRate4  = 2'b01;
	localparam logic [1:0] pixRate8  = 2'b10;
	localparam logic [1:0] pixRate16 = 2'b11;

endpackage

`default_nettype wire

/* source/crtcPkg.sv */
`default_nettype none

package crtcPkg;

	// Register numbers as seen through the CRTC address register
	localparam logic [4:0] regHorizTotal     = 5'd0;
	localparam logic [4:0] regHorizDisplayed = 5'd1;
	localparam logic [4:0] regHorizSyncPos   = 5'd2;
	localparam logic [4:0] regSyncWidth      = 5'd3; // Low nibble horizontal, high nibble vertical
	localparam logic [4:0] regVertTotal      = 5'd4;
	localparam logic [4:0] regVertAdjust     = 5'd5;
	localparam logic [4:0] regVertDisplayed  = 5'd6;
	localparam logic [4:0] regVertSyncPos    = 5'd7;
	localparam logic [4:0] regMaxScanLine    = 5'd9;
	localparam logic [4:0] regCursorStart    = 5'd10;
	localparam logic [4:0] regCursorEnd      = 5'd11;
	localparam logic [4:0] regStartAddrHi    = 5'd12;
	localparam logic [4:0] regStartAddrLo    = 5'd13;
	localparam logic [4:0] regCursorHi       = 5'd14;
	localparam logic [4:0] regCursorLo       = 5'd15;

	localparam int adrWidth      = 14;
	localparam int rowWidth      = 5;
	localparam int hCountWidth   = 8;
	localparam int rowCountWidth = 7;

	// Mode 0 timing, R15 first and R0 last
	localparam logic [15:0][7:0] regResetValues = {
		8'h00, 8'h00, 8'h00, 8'h06, 8'h08, 8'h67, 8'h07, 8'h01,
		8'h22, 8'h20, 8'h00, 8'h26, 8'h28, 8'h62, 8'h50, 8'h7F};

endpackage

`default_nettype wire
